// ==== verilog/ram_pkg.sv ====
package ram_pkg;

	localparam int RAM_ADDR_W = 10;
	localparam int RAM_WORD_W = 32;
	localparam int RAM_DEPTH = 1 << RAM_ADDR_W;

	// Cycles from the sampling edge of a read to registered data at the consumer.
	localparam int RAM_READ_LATENCY = 2;

	typedef logic [RAM_ADDR_W-1:0] ram_addr_t; // Word address.
	typedef logic [RAM_WORD_W-1:0] ram_word_t; // Data word.

endpackage

// ==== verilog/seq_pkg.sv ====
package seq_pkg;

	// One bit wider than the address so that a full 1024-word block fits.
	localparam int BLK_LEN_W = 11;
	localparam int SUM_W = 32;
	localparam int DRAIN_STATE_W = 2;

	typedef logic [BLK_LEN_W-1:0] blk_len_t; // Block length in words.
	typedef logic [SUM_W-1:0] sum_t; // Running checksum, wraps modulo 2^32.

	typedef enum logic [DRAIN_STATE_W-1:0] {
		drain_idle,
		drain_issue,
		drain_flush
	} drain_state_t;

endpackage

// ==== verilog/local_ram_1k32.sv ====
module local_ram_1k32 (
	input logic sys_clk,
	input logic rst,
	input logic cs_n,
	input logic we_n,
	input ram_pkg::ram_addr_t a,
	input ram_pkg::ram_word_t d,
	output ram_pkg::ram_word_t q,
	output logic oe
);
	import ram_pkg::*;

	ram_word_t mem [0:RAM_DEPTH-1];
	ram_word_t rd_word; // First read stage, straight off the array.
	logic wr_en;
	logic rd_en;

	assign wr_en = ~cs_n & ~we_n;
	assign rd_en = ~cs_n & we_n;

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			mem[a] <= d;
		end
	end

	// The array is read on every edge like the block RAM it stands for.
	always_ff @(posedge sys_clk) begin
		rd_word <= mem[a];
		q <= rd_word; // Output register gives the second cycle of latency.
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			oe <= 1'b0;
		end else begin
			oe <= rd_en; // High in the cycle after a read was sampled.
		end
	end

endmodule

// ==== verilog/fill_sequencer.sv ====
module fill_sequencer (
	input logic sys_clk,
	input logic rst,
	input logic ptr_load,
	input ram_pkg::ram_addr_t ptr_addr,
	input logic wr_strobe,
	input ram_pkg::ram_word_t wr_data,
	output logic fill_req,
	output ram_pkg::ram_addr_t fill_addr,
	output ram_pkg::ram_word_t fill_data
);
	import ram_pkg::*;

	ram_addr_t wr_ptr;
	ram_addr_t ptr_base;

	// A load in the same cycle as a strobe places that word at the new address.
	assign ptr_base = ptr_load ? ptr_addr : wr_ptr;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			fill_req <= 1'b0;
		end else begin
			fill_req <= wr_strobe;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_strobe) begin
			fill_addr <= ptr_base;
			fill_data <= wr_data;
		end
	end

	// The pointer is ten bits wide, so stepping past 1023 wraps to 0.
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (wr_strobe) begin
			wr_ptr <= ptr_base + ram_addr_t'(1);
		end else begin
			wr_ptr <= ptr_base;
		end
	end

endmodule

// ==== verilog/ram_port_arbiter.sv ====
module ram_port_arbiter (
	input logic fill_req,
	input ram_pkg::ram_addr_t fill_addr,
	input ram_pkg::ram_word_t fill_data,
	input logic drain_req,
	input ram_pkg::ram_addr_t drain_addr,
	output logic drain_grant,
	output logic cs_n,
	output logic we_n,
	output ram_pkg::ram_addr_t a,
	output ram_pkg::ram_word_t d
);

	// Writes cannot be held off, so a read only goes through on a free cycle.
	assign drain_grant = drain_req & ~fill_req;

	assign cs_n = ~(fill_req | drain_req);
	assign we_n = ~fill_req;

	assign a = fill_req ? fill_addr : drain_addr;
	assign d = fill_data; // Only sampled by the RAM when we_n is low.

endmodule

// ==== verilog/drain_sequencer.sv ====
module drain_sequencer (
	input logic sys_clk,
	input logic rst,
	input logic rd_start,
	input ram_pkg::ram_addr_t rd_addr,
	input seq_pkg::blk_len_t rd_len,
	output logic drain_req,
	output ram_pkg::ram_addr_t drain_addr,
	input logic drain_grant,
	input ram_pkg::ram_word_t ram_q,
	output logic rd_valid,
	output ram_pkg::ram_word_t rd_data,
	output logic rd_busy,
	output logic rd_done,
	output seq_pkg::sum_t rd_sum
);
	import ram_pkg::*;
	import seq_pkg::*;

	drain_state_t state;
	ram_addr_t addr;
	blk_len_t remaining;
	logic [RAM_READ_LATENCY-1:0] in_flight; // One bit per granted read still in the RAM.
	logic issued;
	logic start;
	logic last_issue;
	sum_t sum;

	assign drain_req = (state == drain_issue);
	assign issued = drain_req & drain_grant;
	assign start = (state == drain_idle) & rd_start;
	assign last_issue = issued & (remaining == blk_len_t'(1));
	assign drain_addr = addr;
	assign rd_busy = (state != drain_idle);
	assign rd_sum = sum;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state <= drain_idle;
			rd_done <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			case (state)
				drain_idle: begin
					if (rd_start) begin
						state <= (rd_len == '0) ? drain_flush : drain_issue;
					end
				end
				drain_issue: begin
					if (last_issue) begin
						state <= drain_flush;
					end
				end
				drain_flush: begin
					// Empty here means the last word went out on the previous edge.
					if (in_flight == '0) begin
						state <= drain_idle;
						rd_done <= 1'b1;
					end
				end
				default: state <= drain_idle;
			endcase
		end
	end

	// Address and count are only looked at while busy.
	always_ff @(posedge sys_clk) begin
		if (start) begin
			addr <= rd_addr;
			remaining <= rd_len;
		end else if (issued) begin
			addr <= addr + ram_addr_t'(1); // Wraps from 1023 to 0.
			remaining <= remaining - blk_len_t'(1);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			in_flight <= '0;
			rd_valid <= 1'b0;
			sum <= '0;
		end else begin
			in_flight <= {in_flight[RAM_READ_LATENCY-2:0], issued};
			rd_valid <= in_flight[RAM_READ_LATENCY-1];
			if (start) begin
				sum <= '0;
			end else if (in_flight[RAM_READ_LATENCY-1]) begin
				sum <= sum + ram_q;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (in_flight[RAM_READ_LATENCY-1]) begin
			rd_data <= ram_q; // ram_q is valid exactly when the oldest marker leaves.
		end
	end

endmodule

// ==== verilog/local_ram_subsystem.sv ====
module local_ram_subsystem (
	input logic sys_clk,
	input logic rst,
	input logic ptr_load,
	input ram_pkg::ram_addr_t ptr_addr,
	input logic wr_strobe,
	input ram_pkg::ram_word_t wr_data,
	input logic rd_start,
	input ram_pkg::ram_addr_t rd_addr,
	input seq_pkg::blk_len_t rd_len,
	output logic rd_valid,
	output ram_pkg::ram_word_t rd_data,
	output logic rd_busy,
	output logic rd_done,
	output seq_pkg::sum_t rd_sum,
	output logic mem_oe
);
	import ram_pkg::*;

	logic fill_req;
	ram_addr_t fill_addr;
	ram_word_t fill_data;
	logic drain_req;
	ram_addr_t drain_addr;
	logic drain_grant;
	logic ram_cs_n;
	logic ram_we_n;
	ram_addr_t ram_a;
	ram_word_t ram_d;
	ram_word_t ram_q;
	logic ram_oe;

	assign mem_oe = ram_oe; // Brought out for observation only.

	fill_sequencer i_fill (
		.sys_clk(sys_clk),
		.rst(rst),
		.ptr_load(ptr_load),
		.ptr_addr(ptr_addr),
		.wr_strobe(wr_strobe),
		.wr_data(wr_data),
		.fill_req(fill_req),
		.fill_addr(fill_addr),
		.fill_data(fill_data)
	);

	ram_port_arbiter i_arb (
		.fill_req(fill_req),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.drain_req(drain_req),
		.drain_addr(drain_addr),
		.drain_grant(drain_grant),
		.cs_n(ram_cs_n),
		.we_n(ram_we_n),
		.a(ram_a),
		.d(ram_d)
	);

	drain_sequencer i_drain (
		.sys_clk(sys_clk),
		.rst(rst),
		.rd_start(rd_start),
		.rd_addr(rd_addr),
		.rd_len(rd_len),
		.drain_req(drain_req),
		.drain_addr(drain_addr),
		.drain_grant(drain_grant),
		.ram_q(ram_q),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_busy(rd_busy),
		.rd_done(rd_done),
		.rd_sum(rd_sum)
	);

	local_ram_1k32 i_ram (
		.sys_clk(sys_clk),
		.rst(rst),
		.cs_n(ram_cs_n),
		.we_n(ram_we_n),
		.a(ram_a),
		.d(ram_d),
		.q(ram_q),
		.oe(ram_oe)
	);

endmodule

// ==== tb/tb_local_ram_subsystem.sv ====
module tb_local_ram_subsystem;
	import ram_pkg::*;
	import seq_pkg::*;

	logic sys_clk;
	logic rst;
	logic ptr_load;
	ram_addr_t ptr_addr;
	logic wr_strobe;
	ram_word_t wr_data;
	logic rd_start;
	ram_addr_t rd_addr;
	blk_len_t rd_len;
	logic rd_valid;
	ram_word_t rd_data;
	logic rd_busy;
	logic rd_done;
	sum_t rd_sum;
	logic mem_oe;

	ram_word_t ref_mem [0:RAM_DEPTH-1]; // What the RAM should hold after each strobe.
	ram_addr_t ref_ptr;
	logic [31:0] rng;
	ram_word_t fill_words [$]; // Words of the most recent fill, in strobe order.
	ram_word_t got_words [$];
	int unsigned got_cycles [$]; // Edge number at which each word was seen.
	int unsigned word_base;
	int unsigned done_base;
	int unsigned start_cyc;
	int unsigned cycle_cnt = 0;
	int unsigned done_cnt = 0;
	sum_t done_sum = '0;

	local_ram_subsystem i_dut (
		.sys_clk(sys_clk),
		.rst(rst),
		.ptr_load(ptr_load),
		.ptr_addr(ptr_addr),
		.wr_strobe(wr_strobe),
		.wr_data(wr_data),
		.rd_start(rd_start),
		.rd_addr(rd_addr),
		.rd_len(rd_len),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_busy(rd_busy),
		.rd_done(rd_done),
		.rd_sum(rd_sum),
		.mem_oe(mem_oe)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// Outputs are sampled half a cycle after the edge that set them.
	always @(negedge sys_clk) begin
		if (rd_valid) begin
			got_words.push_back(rd_data);
			got_cycles.push_back(cycle_cnt);
		end
		if (rd_done) begin
			done_cnt <= done_cnt + 1;
			done_sum <= rd_sum;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input ram_word_t exp, input ram_word_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_sum(input string name, input sum_t exp, input sum_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_on_error($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic compare_count(input string name, input int unsigned exp,
			input int unsigned act);
		if (act != exp) begin
			stop_on_error($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	task automatic mark_capture();
		word_base = got_words.size();
		done_base = done_cnt;
	endtask

	task automatic fill_block(input ram_addr_t base, input int unsigned count);
		ram_word_t w;
		int unsigned i;
		fill_words.delete();
		@(posedge sys_clk);
		ptr_load <= 1'b1;
		ptr_addr <= base;
		ref_ptr = base;
		@(posedge sys_clk);
		ptr_load <= 1'b0;
		for (i = 0; i < count; i++) begin
			rng = xorshift32(rng);
			w = rng;
			wr_strobe <= 1'b1;
			wr_data <= w;
			ref_mem[ref_ptr] = w;
			ref_ptr = ref_ptr + ram_addr_t'(1); // Ten bits, so 1023 steps to 0.
			fill_words.push_back(w);
			@(posedge sys_clk);
		end
		wr_strobe <= 1'b0;
	endtask

	task automatic start_drain(input ram_addr_t base, input blk_len_t len);
		@(posedge sys_clk);
		rd_start <= 1'b1;
		rd_addr <= base;
		rd_len <= len;
		@(posedge sys_clk);
		rd_start <= 1'b0;
		@(negedge sys_clk);
		start_cyc = cycle_cnt; // Number of the edge that sampled rd_start.
	endtask

	task automatic wait_done(input string name, input int unsigned limit);
		int unsigned n;
		n = 0;
		while (done_cnt == done_base) begin
			if (n == limit) begin
				stop_on_error($sformatf("timeout in %s: no rd_done within %0d cycles",
					name, limit));
			end
			@(posedge sys_clk);
			n++;
		end
		repeat (4) @(posedge sys_clk); // Room for a stray second pulse to show up.
	endtask

	task automatic check_block(input string name, input ram_addr_t base, input blk_len_t len);
		ram_addr_t a;
		sum_t exp_sum;
		int unsigned n;
		int unsigned i;
		a = base;
		exp_sum = '0;
		n = 32'(len);
		@(negedge sys_clk);
		compare_count({name, " word count"}, n, got_words.size() - word_base);
		for (i = 0; i < n; i++) begin
			compare_word($sformatf("%s word %0d", name, i), ref_mem[a], got_words[word_base + i]);
			exp_sum = exp_sum + ref_mem[a];
			a = a + ram_addr_t'(1);
		end
		compare_count({name, " rd_done pulses"}, 1, done_cnt - done_base);
		compare_sum({name, " sum at done"}, exp_sum, done_sum);
		compare_sum({name, " sum held"}, exp_sum, rd_sum);
	endtask

	task automatic drain_and_check(input string name, input ram_addr_t base,
			input blk_len_t len);
		mark_capture();
		start_drain(base, len);
		wait_done(name, 4096);
		check_block(name, base, len);
	endtask

	task automatic test_reset_state();
		@(negedge sys_clk);
		compare_bit("reset rd_valid", 1'b0, rd_valid);
		compare_bit("reset rd_done", 1'b0, rd_done);
		compare_bit("reset rd_busy", 1'b0, rd_busy);
		compare_bit("reset mem_oe", 1'b0, mem_oe);
	endtask

	task automatic test_fill_drain();
		fill_block(10'h100, 64);
		drain_and_check("fill and drain", 10'h100, 11'd64);
	endtask

	task automatic test_fixed_latency();
		int unsigned i;
		mark_capture();
		start_drain(10'h110, 11'd16);
		for (i = 0; i < 16; i++) begin
			@(negedge sys_clk);
			compare_bit($sformatf("latency mem_oe cycle %0d", i + 1), 1'b1, mem_oe);
		end
		wait_done("fixed latency", 4096);
		check_block("fixed latency", 10'h110, 11'd16);
		for (i = 0; i < 16; i++) begin
			compare_count($sformatf("latency edge of word %0d", i), start_cyc + 3 + i,
				got_cycles[word_base + i]);
		end
	endtask

	task automatic test_write_priority();
		mark_capture();
		start_drain(10'h100, 11'd64);
		fill_block(10'h200, 32); // Disjoint range, written while the drain runs.
		wait_done("write priority", 4096);
		check_block("write priority", 10'h100, 11'd64);
		compare_bit("write priority stall", 1'b1,
			got_cycles[word_base + 63] > start_cyc + 66);
		drain_and_check("write priority new range", 10'h200, 11'd32);
	endtask

	task automatic test_address_wrap();
		int unsigned i;
		fill_block(10'd1020, 8);
		drain_and_check("address wrap", 10'd1020, 11'd8);
		// A separate drain from address 0 shows where the last four words landed.
		mark_capture();
		start_drain(10'd0, 11'd4);
		wait_done("address wrap low words", 4096);
		@(negedge sys_clk);
		compare_count("address wrap low word count", 4, got_words.size() - word_base);
		for (i = 0; i < 4; i++) begin
			compare_word($sformatf("address wrap addr %0d", i), fill_words[4 + i],
				got_words[word_base + i]);
		end
	endtask

	task automatic test_start_while_busy();
		mark_capture();
		start_drain(10'h100, 11'd16);
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		compare_bit("start while busy rd_busy", 1'b1, rd_busy);
		@(posedge sys_clk);
		rd_start <= 1'b1;
		rd_addr <= 10'h200;
		rd_len <= 11'd4;
		@(posedge sys_clk);
		rd_start <= 1'b0;
		wait_done("start while busy", 4096);
		check_block("start while busy", 10'h100, 11'd16);
		repeat (8) @(posedge sys_clk);
		@(negedge sys_clk);
		compare_bit("start while busy idle", 1'b0, rd_busy);
		compare_count("start while busy late done", 1, done_cnt - done_base);
	endtask

	initial begin
		rst = 1'b1;
		ptr_load = 1'b0;
		ptr_addr = '0;
		wr_strobe = 1'b0;
		wr_data = '0;
		rd_start = 1'b0;
		rd_addr = '0;
		rd_len = '0;
		rng = 32'h652386d6;
		word_base = 0;
		done_base = 0;
		start_cyc = 0;
		repeat (5) @(posedge sys_clk);
		rst <= 1'b0;

		test_reset_state();
		test_fill_drain();
		test_fixed_latency();
		test_write_priority();
		test_address_wrap();
		test_start_while_busy();

		$display("TEST OK");
		$finish;
	end

endmodule

// ==== local_ram_subsystem.f ====
verilog/ram_pkg.sv
verilog/seq_pkg.sv
verilog/local_ram_1k32.sv
verilog/fill_sequencer.sv
verilog/ram_port_arbiter.sv
verilog/drain_sequencer.sv
verilog/local_ram_subsystem.sv
tb/tb_local_ram_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

TOP=tb_local_ram_subsystem
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-f local_ram_subsystem.f

# The log is searched below, so the simulator's own exit status is not used here.
"./$BUILD_DIR/V$TOP" 2>&1 | tee "$LOG"

if grep -qx "TEST OK" "$LOG"; then
	echo "Simulation passed."
	exit 0
fi

echo "Simulation failed, see $LOG."
exit 1
